//--- arcade_pkg.sv
// Arcade board package with the difficulty type, APB register map and status bit positions
`default_nettype none

package arcade_pkg;

    // Game difficulty as the DIP switches expect it
    typedef enum logic [1:0] {
        DIFF_EASY   = 2'd0,
        DIFF_NORMAL = 2'd1,
        DIFF_HARD   = 2'd2,
        DIFF_VHARD  = 2'd3
    } difficulty_t;

    // APB byte addresses
    localparam logic [3:0] REG_STATUS = 4'h0;
    localparam logic [3:0] REG_JOY1   = 4'h4;
    localparam logic [3:0] REG_JOY2   = 4'h8;
    localparam logic [3:0] REG_ID     = 4'hc;

    localparam logic [31:0] CORE_ID = 32'h4152_4331; // "ARC1"

    // Bit positions inside the OSD status word
    localparam logic [4:0] ST_PAUSE      = 5'd1;
    localparam logic [4:0] ST_LEVEL_LO   = 5'd2;  // Two bits wide
    localparam logic [4:0] ST_TEST       = 5'd4;
    localparam logic [4:0] ST_LIVES_LO   = 5'd5;  // Two bits wide
    localparam logic [4:0] ST_FILTER_OFF = 5'd9;
    localparam logic [4:0] ST_RST_REQ    = 5'd15;

    localparam int JOY_W = 5; // Joystick bits the game uses

endpackage

`default_nettype wire

//--- osd_status_regs.sv
// OSD register block, an APB slave with status, joystick and core ID registers
`default_nettype none

module osd_status_regs import arcade_pkg::*; (
    input  wire         clk_sys,
    input  wire         rst_n,
    input  wire  [ 3:0] paddr,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic [31:0] status,
    output logic [31:0] joy1,
    output logic [31:0] joy2
);

    logic access;
    logic addr_ok;
    logic wr_en;

    assign access = psel & penable;
    assign pready = 1'b1;           // Zero wait states

    // Read mux that also flags addresses outside the map
    always_comb begin
        addr_ok = 1'b1;
        prdata  = '0;
        case (paddr)
            REG_STATUS: prdata = status;
            REG_JOY1:   prdata = joy1;
            REG_JOY2:   prdata = joy2;
            REG_ID:     prdata = CORE_ID;
            default:    addr_ok = 1'b0;
        endcase
    end

    // ID is read only, so writing it is an error too
    assign pslverr = access & (~addr_ok | (pwrite & (paddr == REG_ID)));
    assign wr_en   = access & pwrite & ~pslverr;

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            status <= '0;
            joy1   <= '0;
            joy2   <= '0;
        end else if (wr_en) begin
            case (paddr)
                REG_STATUS: status <= pwdata;
                REG_JOY1:   joy1   <= pwdata;
                REG_JOY2:   joy2   <= pwdata;
                default:    ;      // Blocked by pslverr
            endcase
        end
    end

endmodule

`default_nettype wire

//--- dip_decoder.sv
// DIP decoder turning OSD status bits and cabinet inputs into registered game controls
`default_nettype none

module dip_decoder import arcade_pkg::*; (
    input  wire               clk_sys,
    input  wire               rst_n,
    input  wire  [31:0]       status,
    input  wire  [31:0]       joy1,
    input  wire  [31:0]       joy2,
    input  wire  [ 1:0]       coin,
    input  wire               pause_button,
    output logic              dip_pause_n,
    output difficulty_t       dip_level,
    output logic [ 1:0]       dip_lives,
    output logic              service,
    output logic              coin_input,
    output logic [JOY_W-1:0]  game_joystick1,
    output logic [JOY_W-1:0]  game_joystick2,
    output logic              en_filter,
    output logic              game_rst_n
);

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            dip_pause_n    <= 1'b1;
            dip_level      <= DIFF_NORMAL; // Matches an all-zero status word
            dip_lives      <= '0;
            service        <= 1'b0;
            coin_input     <= 1'b0;
            game_joystick1 <= '0;
            game_joystick2 <= '0;
            en_filter      <= 1'b1;
            game_rst_n     <= 1'b0;
        end else begin
            // OSD menu lists Normal first, so codes 0 and 1 swap
            case (status[ST_LEVEL_LO +: 2])
                2'd0:    dip_level <= DIFF_NORMAL;
                2'd1:    dip_level <= DIFF_EASY;
                2'd2:    dip_level <= DIFF_HARD;
                default: dip_level <= DIFF_VHARD;
            endcase

            dip_pause_n    <= ~(status[ST_PAUSE] | pause_button);
            dip_lives      <= status[ST_LIVES_LO +: 2];
            service        <= status[ST_TEST];
            coin_input     <= |coin;                // Either slot
            game_joystick1 <= joy1[JOY_W-1:0];
            game_joystick2 <= joy2[JOY_W-1:0];
            en_filter      <= ~status[ST_FILTER_OFF];

            // Game stays in reset while the OSD request bit is held
            game_rst_n     <= ~status[ST_RST_REQ];
        end
    end

endmodule

`default_nettype wire

//--- video_timing.sv
// Video timing generator with pixel clock enable, raster counters, blanking and sync
`default_nettype none

module video_timing #(
    parameter int CEN_DIV      = 4,
    parameter int H_ACTIVE     = 256,
    parameter int H_TOTAL      = 320,
    parameter int H_SYNC_START = 272,
    parameter int H_SYNC_LEN   = 32,
    parameter int V_ACTIVE     = 224,
    parameter int V_TOTAL      = 264,
    parameter int V_SYNC_START = 240,
    parameter int V_SYNC_LEN   = 4
) (
    input  wire        clk_sys,
    input  wire        rst_n,
    output logic       pxl_cen,
    output logic [9:0] hcount,
    output logic [9:0] vcount,
    output logic       hb,
    output logic       vb,
    output logic       hs,
    output logic       vs
);

    localparam int CW = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;
    localparam logic [CW-1:0] CEN_LAST = CW'(CEN_DIV - 1);

    localparam logic [9:0] H_ACT  = 10'(H_ACTIVE);
    localparam logic [9:0] H_LAST = 10'(H_TOTAL - 1);
    localparam logic [9:0] H_SS   = 10'(H_SYNC_START);
    localparam logic [9:0] H_SE   = 10'(H_SYNC_START + H_SYNC_LEN);
    localparam logic [9:0] V_ACT  = 10'(V_ACTIVE);
    localparam logic [9:0] V_LAST = 10'(V_TOTAL - 1);
    localparam logic [9:0] V_SS   = 10'(V_SYNC_START);
    localparam logic [9:0] V_SE   = 10'(V_SYNC_START + V_SYNC_LEN);

    logic [CW-1:0] cen_cnt;
    logic [9:0]    h_next;
    logic [9:0]    v_next;

    // One pulse every CEN_DIV clocks
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            cen_cnt <= '0;
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= (cen_cnt == CEN_LAST);
            cen_cnt <= (cen_cnt == CEN_LAST) ? '0 : cen_cnt + 1'b1;
        end
    end

    always_comb begin
        h_next = hcount + 10'd1;
        v_next = vcount;
        if (hcount == H_LAST) begin
            h_next = '0;
            v_next = (vcount == V_LAST) ? '0 : vcount + 10'd1;
        end
    end

    // Flags use the next count so they line up with the counters
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
            hb     <= 1'b0;
            vb     <= 1'b0;
            hs     <= 1'b0;
            vs     <= 1'b0;
        end else if (pxl_cen) begin
            hcount <= h_next;
            vcount <= v_next;
            hb     <= (h_next >= H_ACT);
            vb     <= (v_next >= V_ACT);
            hs     <= (h_next >= H_SS) && (h_next < H_SE);
            vs     <= (v_next >= V_SS) && (v_next < V_SE);
        end
    end

endmodule

`default_nettype wire

//--- colour_expand.sv
// Colour path expanding 3-bit game colour to 6-bit VGA with blanking and a horizontal filter
`default_nettype none

module colour_expand (
    input  wire        clk_sys,
    input  wire        rst_n,
    input  wire        pxl_cen,
    input  wire  [2:0] red,
    input  wire  [2:0] green,
    input  wire  [2:0] blue,
    input  wire        hb,
    input  wire        vb,
    input  wire        hs,
    input  wire        vs,
    input  wire        en_filter,
    output logic [5:0] vga_r,
    output logic [5:0] vga_g,
    output logic [5:0] vga_b,
    output logic       vga_hs,
    output logic       vga_vs
);

    // Bits on top, MSB repeated, top two bits at the bottom
    function automatic logic [5:0] expand(input logic [2:0] c);
        return {c, c[2], c[2:1]};
    endfunction

    function automatic logic [5:0] avg(input logic [5:0] a, input logic [5:0] b);
        logic [6:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[6:1];               // Floor of the mean
    endfunction

    logic [5:0] r_cur, g_cur, b_cur;
    logic [5:0] r_prev, g_prev, b_prev; // Last active pixel on this line
    logic [5:0] r_ref, g_ref, b_ref;
    logic       prev_ok;
    logic       blank;

    assign blank = hb | vb;
    assign r_cur = expand(red);
    assign g_cur = expand(green);
    assign b_cur = expand(blue);

    // First pixel after blanking is paired with itself
    assign r_ref = prev_ok ? r_prev : r_cur;
    assign g_ref = prev_ok ? g_prev : g_cur;
    assign b_ref = prev_ok ? b_prev : b_cur;

    always_ff @(posedge clk_sys) begin
        if (pxl_cen) begin
            r_prev <= r_cur;
            g_prev <= g_cur;
            b_prev <= b_cur;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            vga_r   <= '0;
            vga_g   <= '0;
            vga_b   <= '0;
            vga_hs  <= 1'b0;
            vga_vs  <= 1'b0;
            prev_ok <= 1'b0;
        end else if (pxl_cen) begin
            vga_hs  <= hs;     // Same pixel delay as the colour
            vga_vs  <= vs;
            prev_ok <= ~blank;
            if (blank) begin
                vga_r <= '0;
                vga_g <= '0;
                vga_b <= '0;
            end else if (en_filter) begin
                vga_r <= avg(r_cur, r_ref);
                vga_g <= avg(g_cur, g_ref);
                vga_b <= avg(b_cur, b_ref);
            end else begin
                vga_r <= r_cur;
                vga_g <= g_cur;
                vga_b <= b_cur;
            end
        end
    end

endmodule

`default_nettype wire

//--- arcade_board.sv
// Arcade board top level joining the OSD registers, DIP decoder, video timing and colour path
`default_nettype none

module arcade_board import arcade_pkg::*; #(
    parameter int CEN_DIV      = 4,
    parameter int H_ACTIVE     = 256,
    parameter int H_TOTAL      = 320,
    parameter int H_SYNC_START = 272,
    parameter int H_SYNC_LEN   = 32,
    parameter int V_ACTIVE     = 224,
    parameter int V_TOTAL      = 264,
    parameter int V_SYNC_START = 240,
    parameter int V_SYNC_LEN   = 4
) (
    input  wire               clk_sys,
    input  wire               rst_n,
    // APB from the I/O controller
    input  wire  [ 3:0]       paddr,
    input  wire               psel,
    input  wire               penable,
    input  wire               pwrite,
    input  wire  [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    // Cabinet
    input  wire  [ 1:0]       coin,
    input  wire               pause_button,
    // Game side
    input  wire  [ 2:0]       red,
    input  wire  [ 2:0]       green,
    input  wire  [ 2:0]       blue,
    output logic [ 9:0]       hcount,
    output logic [ 9:0]       vcount,
    output logic              dip_pause_n,
    output difficulty_t       dip_level,
    output logic [ 1:0]       dip_lives,
    output logic              service,
    output logic              coin_input,
    output logic [JOY_W-1:0]  game_joystick1,
    output logic [JOY_W-1:0]  game_joystick2,
    output logic              game_rst_n,
    // VGA
    output logic [ 5:0]       vga_r,
    output logic [ 5:0]       vga_g,
    output logic [ 5:0]       vga_b,
    output logic              vga_hs,
    output logic              vga_vs
);

    logic [31:0] status, joy1, joy2;
    logic        en_filter;
    logic        pxl_cen;
    logic        hb, vb, hs, vs;

    osd_status_regs u_regs (
        .clk_sys (clk_sys), .rst_n   (rst_n),
        .paddr   (paddr),   .psel    (psel),
        .penable (penable), .pwrite  (pwrite),
        .pwdata  (pwdata),  .prdata  (prdata),
        .pready  (pready),  .pslverr (pslverr),
        .status  (status),  .joy1    (joy1),
        .joy2    (joy2)
    );

    dip_decoder u_dip (
        .clk_sys        (clk_sys),        .rst_n          (rst_n),
        .status         (status),         .joy1           (joy1),
        .joy2           (joy2),           .coin           (coin),
        .pause_button   (pause_button),   .dip_pause_n    (dip_pause_n),
        .dip_level      (dip_level),      .dip_lives      (dip_lives),
        .service        (service),        .coin_input     (coin_input),
        .game_joystick1 (game_joystick1), .game_joystick2 (game_joystick2),
        .en_filter      (en_filter),      .game_rst_n     (game_rst_n)
    );

    video_timing #(
        .CEN_DIV      (CEN_DIV),
        .H_ACTIVE     (H_ACTIVE),     .H_TOTAL    (H_TOTAL),
        .H_SYNC_START (H_SYNC_START), .H_SYNC_LEN (H_SYNC_LEN),
        .V_ACTIVE     (V_ACTIVE),     .V_TOTAL    (V_TOTAL),
        .V_SYNC_START (V_SYNC_START), .V_SYNC_LEN (V_SYNC_LEN)
    ) u_timing (
        .clk_sys (clk_sys), .rst_n  (rst_n),
        .pxl_cen (pxl_cen), .hcount (hcount),
        .vcount  (vcount),  .hb     (hb),
        .vb      (vb),      .hs     (hs),
        .vs      (vs)
    );

    colour_expand u_colour (
        .clk_sys   (clk_sys),   .rst_n  (rst_n),
        .pxl_cen   (pxl_cen),   .red    (red),
        .green     (green),     .blue   (blue),
        .hb        (hb),        .vb     (vb),
        .hs        (hs),        .vs     (vs),
        .en_filter (en_filter), .vga_r  (vga_r),
        .vga_g     (vga_g),     .vga_b  (vga_b),
        .vga_hs    (vga_hs),    .vga_vs (vga_vs)
    );

endmodule

`default_nettype wire

//--- arcade_board_chk.sv
// Assertion checker for the arcade board APB handshake and video sync rules
`default_nettype none

module arcade_board_chk (
    input wire clk_sys,
    input wire rst_n,
    input wire psel,
    input wire pready,
    input wire pxl_cen,
    input wire vga_hs,
    input wire vga_vs
);
    timeunit 1ns;
    timeprecision 100ps;

    // Zero wait states on every transfer
    assert property (@(posedge clk_sys) disable iff (!rst_n) psel |-> pready)
        else $error("pready low while psel high");

    assert property (@(posedge clk_sys) disable iff (!rst_n) pxl_cen |=> !pxl_cen)
        else $error("pxl_cen high for two cycles");

    // Horizontal sync edge kept apart from vertical sync changes
    assert property (@(posedge clk_sys) disable iff (!rst_n)
                     !($rose(vga_hs) && $changed(vga_vs)))
        else $error("vga_hs rose while vga_vs changed");

endmodule

bind arcade_board arcade_board_chk chk_i (
    .clk_sys (clk_sys),
    .rst_n   (rst_n),
    .psel    (psel),
    .pready  (pready),
    .pxl_cen (pxl_cen),
    .vga_hs  (vga_hs),
    .vga_vs  (vga_vs)
);

`default_nettype wire

//--- tb_arcade_board.sv
// Testbench for the arcade board covering APB registers, DIP decoding and the VGA colour path
`default_nettype none

module tb_arcade_board;
    import arcade_pkg::*;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_NS = 40;
    localparam int CEN_DIV = 4;
    localparam int H_ACTIVE = 16, H_TOTAL = 24, H_SYNC_START = 18, H_SYNC_LEN = 3;
    localparam int V_ACTIVE = 8, V_TOTAL = 12, V_SYNC_START = 9, V_SYNC_LEN = 2;
    localparam int FRAME_CYC = H_TOTAL * V_TOTAL * CEN_DIV;

    typedef struct packed {
        logic [31:0] status, joy1, joy2;
        logic [1:0]  coin;
        logic        button;
        logic [17:0] expect_out;   // pause_n, level, lives, service, coin, joy1, joy2, rst_n
    } row_t;

    logic clk_sys = 1'b0, rst_n = 1'b0;
    logic [3:0] paddr = '0;
    logic psel = 1'b0, penable = 1'b0, pwrite = 1'b0;
    logic [31:0] pwdata = '0;
    logic [31:0] prdata;
    logic pready, pslverr;
    logic [1:0] coin = '0;
    logic pause_button = 1'b0;
    logic [2:0] red = '0, green = '0, blue = '0;
    logic [9:0] hcount, vcount;
    logic dip_pause_n, service, coin_input, game_rst_n, vga_hs, vga_vs;
    difficulty_t dip_level;
    logic [1:0] dip_lives;
    logic [JOY_W-1:0] game_joystick1, game_joystick2;
    logic [5:0] vga_r, vga_g, vga_b;

    row_t table_q[$];
    int errors = 0;
    logic [31:0] seed = 32'hb78f_b65a;

    arcade_board #(
        .CEN_DIV(CEN_DIV), .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL),
        .H_SYNC_START(H_SYNC_START), .H_SYNC_LEN(H_SYNC_LEN), .V_ACTIVE(V_ACTIVE),
        .V_TOTAL(V_TOTAL), .V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN)
    ) arcade_board_i (.*);

    always #(CLK_NS / 2) clk_sys = ~clk_sys;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Three bits on top, MSB again, then the top two bits
    function automatic logic [5:0] widen_channel(input logic [2:0] c);
        return {c[2], c[1], c[0], c[2], c[2], c[1]};
    endfunction

    function automatic logic [5:0] mean_floor(input logic [5:0] a, input logic [5:0] b);
        int s;
        s = int'(a) + int'(b);
        return 6'(s / 2);
    endfunction

    task automatic add_row(input logic [31:0] st, input logic [31:0] j1, input logic [31:0] j2,
                           input logic [1:0] c, input logic b, input logic [17:0] exp_out);
        row_t r;
        r.status = st;
        r.joy1 = j1;
        r.joy2 = j2;
        r.coin = c;
        r.button = b;
        r.expect_out = exp_out;
        table_q.push_back(r);
    endtask

    task automatic apb_write(input logic [3:0] a, input logic [31:0] d, output logic err);
        paddr = a;
        pwdata = d;
        pwrite = 1'b1;
        psel = 1'b1;
        @(posedge clk_sys);
        #2;
        penable = 1'b1;
        #10 err = pslverr;              // Sampled in the access phase
        @(posedge clk_sys);
        #2;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] a, output logic [31:0] d, output logic err);
        paddr = a;
        pwrite = 1'b0;
        psel = 1'b1;
        @(posedge clk_sys);
        #2;
        penable = 1'b1;
        #10;
        d = prdata;
        err = pslverr;
        @(posedge clk_sys);
        #2;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic expect_read(input logic [3:0] a, input logic [31:0] d, input logic e);
        logic [31:0] got;
        logic err;
        apb_read(a, got, err);
        if (got !== d || err !== e) begin
            $display("Mismatch at %0t: read 0x%0h gave %h err %b, expected %h err %b",
                     $time, a, got, err, d, e);
            errors++;
        end
    endtask

    task automatic expect_write_err(input logic [3:0] a, input logic [31:0] d, input logic e);
        logic err;
        apb_write(a, d, err);
        if (err !== e) begin
            $display("Mismatch at %0t: write 0x%0h pslverr %b expected %b", $time, a, err, e);
            errors++;
        end
    endtask

    // Checks each pixel one pixel after its colour was driven
    task automatic run_video(input int frames, input logic filter_on);
        logic [9:0] last_h, last_v, seen_h, exp_h, exp_v;
        logic [2:0] lr, lg, lb;
        logic [5:0] er, eg, eb, pr, pg, pb;
        logic prev_valid, blank, ehs, evs, hs_d, vs_d, counting;
        int px_left, hs_rises, vs_checks, cycles;
        prev_valid = 1'b0;
        counting = 1'b0;
        hs_rises = 0;
        vs_checks = 0;
        hs_d = vga_hs;
        vs_d = vga_vs;
        seen_h = hcount;
        forever begin
            @(posedge clk_sys);
            #2;
            if (hcount == 0 && vcount == 0 && seen_h != 0) break;
            seen_h = hcount;
        end
        px_left = frames * H_TOTAL * V_TOTAL;
        while (px_left > 0) begin
            seed = lcg_next(seed);
            {lr, lg, lb} = seed[30:22];
            red = lr;
            green = lg;
            blue = lb;
            last_h = hcount;
            last_v = vcount;
            cycles = 0;
            do begin
                @(posedge clk_sys);
                #2;
                cycles++;
            end while (hcount == last_h);
            // Raster steps one pixel, wrapping at the line and frame ends
            if (last_h == H_TOTAL - 1) begin
                exp_h = '0;
                exp_v = (last_v == V_TOTAL - 1) ? '0 : last_v + 1'b1;
            end else begin
                exp_h = last_h + 1'b1;
                exp_v = last_v;
            end
            if (hcount !== exp_h || vcount !== exp_v) begin
                $display("Mismatch at %0t: raster at (%0d,%0d), expected (%0d,%0d)",
                         $time, hcount, vcount, exp_h, exp_v);
                errors++;
            end
            if (cycles != CEN_DIV) begin
                $display("Mismatch at %0t: pixel lasted %0d clocks, expected %0d",
                         $time, cycles, CEN_DIV);
                errors++;
            end
            blank = (last_h >= H_ACTIVE) || (last_v >= V_ACTIVE);
            ehs = (last_h >= H_SYNC_START) && (last_h < H_SYNC_START + H_SYNC_LEN);
            evs = (last_v >= V_SYNC_START) && (last_v < V_SYNC_START + V_SYNC_LEN);
            er = widen_channel(lr);
            eg = widen_channel(lg);
            eb = widen_channel(lb);
            if (!prev_valid) {pr, pg, pb} = {er, eg, eb};
            prev_valid = !blank;
            {pr, pg, pb} = {mean_floor(er, pr), mean_floor(eg, pg), mean_floor(eb, pb)};
            if (filter_on) {er, eg, eb} = {pr, pg, pb};
            {pr, pg, pb} = {widen_channel(lr), widen_channel(lg), widen_channel(lb)};
            if (blank) {er, eg, eb} = '0;
            if ({vga_r, vga_g, vga_b} !== {er, eg, eb}) begin
                $display("Mismatch at %0t: pixel (%0d,%0d) rgb %h/%h/%h, expected %h/%h/%h",
                         $time, last_h, last_v, vga_r, vga_g, vga_b, er, eg, eb);
                errors++;
            end
            if (vga_hs !== ehs || vga_vs !== evs) begin
                $display("Mismatch at %0t: pixel (%0d,%0d) syncs %b%b, expected %b%b",
                         $time, last_h, last_v, vga_hs, vga_vs, ehs, evs);
                errors++;
            end
            if (vga_hs && !hs_d) hs_rises++;
            if (vga_vs && !vs_d) begin
                if (counting && hs_rises != V_TOTAL) begin
                    $display("Mismatch at %0t: %0d hsync pulses per vsync, expected %0d",
                             $time, hs_rises, V_TOTAL);
                    errors++;
                end
                if (counting) vs_checks++;
                counting = 1'b1;
                hs_rises = 0;
            end
            hs_d = vga_hs;
            vs_d = vga_vs;
            px_left--;
        end
        if (frames > 1 && vs_checks == 0) begin
            $display("No complete vsync period was seen during the video test");
            errors++;
        end
    endtask

    initial begin
        logic err;
        // Expected: pause_n, level, lives, service, coin, joy1, joy2, game_rst_n
        add_row(32'h0,    32'h0,   32'h0,   2'b00, 1'b0,
                {1'b1, DIFF_NORMAL, 2'd0, 2'b00, 5'h00, 5'h00, 1'b1});
        add_row(32'h64,   32'h1f5, 32'habc, 2'b00, 1'b0,
                {1'b1, DIFF_EASY, 2'd3, 2'b00, 5'h15, 5'h1c, 1'b1});
        add_row(32'h18,   32'h3,   32'h20,  2'b01, 1'b0,
                {1'b1, DIFF_HARD, 2'd0, 2'b11, 5'h03, 5'h00, 1'b1});
        add_row(32'h2c,   32'h0,   32'h1f,  2'b10, 1'b0,
                {1'b1, DIFF_VHARD, 2'd1, 2'b01, 5'h00, 5'h1f, 1'b1});
        add_row(32'h2,    32'h0,   32'h0,   2'b00, 1'b0,
                {1'b0, DIFF_NORMAL, 2'd0, 2'b00, 5'h00, 5'h00, 1'b1});
        add_row(32'h0,    32'h0,   32'h0,   2'b00, 1'b1,
                {1'b0, DIFF_NORMAL, 2'd0, 2'b00, 5'h00, 5'h00, 1'b1});
        add_row(32'h2,    32'h0,   32'h0,   2'b11, 1'b1,
                {1'b0, DIFF_NORMAL, 2'd0, 2'b01, 5'h00, 5'h00, 1'b1});
        add_row(32'h8000, 32'h0,   32'h0,   2'b00, 1'b0,
                {1'b1, DIFF_NORMAL, 2'd0, 2'b00, 5'h00, 5'h00, 1'b0});
        add_row(32'h0,    32'h0,   32'h0,   2'b00, 1'b0,
                {1'b1, DIFF_NORMAL, 2'd0, 2'b00, 5'h00, 5'h00, 1'b1});

        repeat (3) @(posedge clk_sys);
        #2 rst_n = 1'b1;

        // Register map
        expect_write_err(REG_STATUS, 32'h1234_5678, 1'b0);
        expect_write_err(REG_JOY1, 32'hcafe_0001, 1'b0);
        expect_write_err(REG_JOY2, 32'h0bad_f00d, 1'b0);
        expect_write_err(REG_ID, 32'hffff_ffff, 1'b1);
        expect_write_err(4'h6, 32'hffff_ffff, 1'b1);
        expect_read(REG_STATUS, 32'h1234_5678, 1'b0);
        expect_read(REG_JOY1, 32'hcafe_0001, 1'b0);
        expect_read(REG_JOY2, 32'h0bad_f00d, 1'b0);
        expect_read(REG_ID, CORE_ID, 1'b0);
        expect_read(4'h6, 32'h0, 1'b1);

        // Decoder table
        foreach (table_q[i]) begin
            coin = table_q[i].coin;
            pause_button = table_q[i].button;
            apb_write(REG_JOY1, table_q[i].joy1, err);
            apb_write(REG_JOY2, table_q[i].joy2, err);
            // Game reset only follows the status word
            if (i > 0 && game_rst_n !== table_q[i - 1].expect_out[0]) begin
                $display("Mismatch at %0t: row %0d game_rst_n %b ahead of status, expected %b",
                         $time, i, game_rst_n, table_q[i - 1].expect_out[0]);
                errors++;
            end
            apb_write(REG_STATUS, table_q[i].status, err);
            repeat (2) @(posedge clk_sys);
            #2;
            if ({dip_pause_n, dip_level, dip_lives, service, coin_input, game_joystick1,
                 game_joystick2, game_rst_n} !== table_q[i].expect_out) begin
                $display("Mismatch at %0t: row %0d decoder outputs %h, expected %h", $time, i,
                         {dip_pause_n, dip_level, dip_lives, service, coin_input,
                          game_joystick1, game_joystick2, game_rst_n}, table_q[i].expect_out);
                errors++;
            end
        end

        // Video with the filter off, then on
        apb_write(REG_STATUS, 32'h200, err);
        run_video(2, 1'b0);
        apb_write(REG_STATUS, 32'h0, err);
        run_video(1, 1'b1);

        $display("Test finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog sized from the table and the video frames
    initial begin
        int limit_cyc;
        wait (rst_n);
        limit_cyc = (table_q.size() + 9) * 40 + 6 * FRAME_CYC + 200;
        #(limit_cyc * CLK_NS);
        $display("Timeout, the test did not finish in time");
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
arcade_pkg.sv
osd_status_regs.sv
dip_decoder.sv
video_timing.sv
colour_expand.sv
arcade_board.sv
arcade_board_chk.sv
tb_arcade_board.sv

//--- Makefile
# Verilator flow for the arcade board testbench

VERILATOR ?= verilator
TOP       ?= tb_arcade_board
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "Something failed" $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
